//--- rtl/linear_pkg.sv
`default_nettype none

package linear_pkg;

  // default activation format, total bits and fractional bits
  localparam int DEF_IN_WIDTH = 8;
  localparam int DEF_IN_FRAC = 3;

  // default weight format
  localparam int DEF_W_WIDTH = 8;
  localparam int DEF_W_FRAC = 3;

  // default bias format
  localparam int DEF_BIAS_WIDTH = 8;
  localparam int DEF_BIAS_FRAC = 3;

  // default output format
  localparam int DEF_OUT_WIDTH = 8;
  localparam int DEF_OUT_FRAC = 3;

  // elements per input beat, output lanes, and beats per reduction
  localparam int DEF_IN_PAR = 4;
  localparam int DEF_OUT_PAR = 2;
  localparam int DEF_IN_DEPTH = 4;

  // one spare bit above the widest operand so the saturation compare never wraps
  localparam int SAT_GUARD_BITS = 1;

  // width needed to add up a number of terms of the given width without overflow
  function automatic int sum_width(input int width, input int terms);
    return width + $clog2(terms);
  endfunction

  function automatic int fdp_width(input int in_width, input int w_width, input int in_par);
    return sum_width(in_width + w_width, in_par);
  endfunction

  function automatic int acc_width(input int in_width, input int w_width, input int in_par,
                                   input int in_depth);
    return sum_width(fdp_width(in_width, w_width, in_par), in_depth);
  endfunction

  // distance between two binary point positions, the direction is decided by the caller
  function automatic int frac_shift(input int in_frac, input int out_frac);
    return (out_frac > in_frac) ? out_frac - in_frac : in_frac - out_frac;
  endfunction

endpackage

`default_nettype wire

//--- rtl/fixed_dot_product.sv
`default_nettype none

module fixed_dot_product
  import linear_pkg::*;
#(
  parameter int IN_WIDTH = DEF_IN_WIDTH,
  parameter int W_WIDTH  = DEF_W_WIDTH,
  parameter int IN_PAR   = DEF_IN_PAR
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [IN_WIDTH-1:0]                          data_in  [IN_PAR-1:0],
  input  logic [W_WIDTH-1:0]                           weight   [IN_PAR-1:0],
  input  logic                                         in_valid,
  output logic                                         in_ready,
  output logic [fdp_width(IN_WIDTH, W_WIDTH, IN_PAR)-1:0] data_out,
  output logic                                         out_valid,
  input  logic                                         out_ready
);

  localparam int PROD_WIDTH = IN_WIDTH + W_WIDTH;
  localparam int FDP_WIDTH = fdp_width(IN_WIDTH, W_WIDTH, IN_PAR);
  localparam int LEVELS = $clog2(IN_PAR);
  localparam int LEAVES = 1 << LEVELS;

  // heap-ordered adder tree, node 1 is the root and the leaves start at LEAVES
  logic signed [FDP_WIDTH-1:0] node [1:2*LEAVES-1];
  logic [FDP_WIDTH-1:0] data_q;
  logic valid_q;

  for (genvar k = 0; k < LEAVES; k++) begin : g_leaf
    if (k < IN_PAR) begin : g_mul
      logic signed [PROD_WIDTH-1:0] prod;
      assign prod = $signed(data_in[k]) * $signed(weight[k]);
      assign node[LEAVES+k] = prod;
    end else begin : g_pad
      // unused leaves when IN_PAR is not a power of two
      assign node[LEAVES+k] = '0;
    end
  end

  for (genvar n = 1; n < LEAVES; n++) begin : g_add
    assign node[n] = node[2*n] + node[2*n+1];
  end

  // the output register can take a new sum when it is empty or being drained
  assign in_ready = ~valid_q | out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= node[1];
    end
  end

  assign data_out = data_q;
  assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- rtl/fixed_accumulator.sv
`default_nettype none

module fixed_accumulator
  import linear_pkg::*;
#(
  parameter int IN_WIDTH = 18,
  parameter int IN_DEPTH = DEF_IN_DEPTH
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [IN_WIDTH-1:0]                       data_in,
  input  logic                                      in_valid,
  output logic                                      in_ready,
  output logic [sum_width(IN_WIDTH, IN_DEPTH)-1:0]  data_out,
  output logic                                      out_valid,
  input  logic                                      out_ready
);

  localparam int ACC_WIDTH = sum_width(IN_WIDTH, IN_DEPTH);
  localparam int CNT_WIDTH = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam logic [CNT_WIDTH-1:0] LAST_BEAT = CNT_WIDTH'(IN_DEPTH - 1);

  logic [CNT_WIDTH-1:0] beat_cnt;
  logic signed [ACC_WIDTH-1:0] sum_q;
  logic signed [ACC_WIDTH-1:0] beat_ext;
  logic valid_q;

  assign beat_ext = ACC_WIDTH'($signed(data_in));

  // no new beats are taken while a finished sum waits for the consumer
  assign in_ready = ~valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      sum_q <= '0;
      valid_q <= 1'b0;
    end else if (valid_q) begin
      if (out_ready) begin
        // handoff done, the next reduction starts from zero
        valid_q <= 1'b0;
        sum_q <= '0;
      end
    end else if (in_valid) begin
      sum_q <= sum_q + beat_ext;
      if (beat_cnt == LAST_BEAT) begin
        beat_cnt <= '0;
        valid_q <= 1'b1;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  assign data_out = sum_q;
  assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- rtl/fixed_rounding.sv
`default_nettype none

module fixed_rounding
  import linear_pkg::*;
#(
  parameter int IN_SIZE   = 1,
  parameter int IN_WIDTH  = DEF_IN_WIDTH,
  parameter int IN_FRAC   = DEF_IN_FRAC,
  parameter int OUT_WIDTH = DEF_OUT_WIDTH,
  parameter int OUT_FRAC  = DEF_OUT_FRAC
) (
  input  logic [IN_WIDTH-1:0]  data_in  [IN_SIZE-1:0],
  output logic [OUT_WIDTH-1:0] data_out [IN_SIZE-1:0]
);

  localparam int SHIFT = frac_shift(IN_FRAC, OUT_FRAC);
  // a left shift grows the value, a right shift never does
  localparam int GROWN = (OUT_FRAC > IN_FRAC) ? IN_WIDTH + SHIFT : IN_WIDTH;
  localparam int EXT_WIDTH = ((GROWN > OUT_WIDTH) ? GROWN : OUT_WIDTH) + SAT_GUARD_BITS;

  // largest and smallest values of the signed output format, in the wide domain
  localparam logic signed [EXT_WIDTH-1:0] SAT_MAX =
    {{(EXT_WIDTH-OUT_WIDTH+1){1'b0}}, {(OUT_WIDTH-1){1'b1}}};
  localparam logic signed [EXT_WIDTH-1:0] SAT_MIN =
    {{(EXT_WIDTH-OUT_WIDTH+1){1'b1}}, {(OUT_WIDTH-1){1'b0}}};

  for (genvar i = 0; i < IN_SIZE; i++) begin : g_elem
    logic signed [EXT_WIDTH-1:0] ext;
    logic signed [EXT_WIDTH-1:0] shifted;

    assign ext = EXT_WIDTH'($signed(data_in[i]));

    if (OUT_FRAC > IN_FRAC) begin : g_left
      assign shifted = ext <<< SHIFT;
    end else begin : g_right
      // arithmetic shift drops the low bits, which rounds toward minus infinity
      assign shifted = ext >>> SHIFT;
    end

    always_comb begin
      if (shifted > SAT_MAX) begin
        data_out[i] = SAT_MAX[OUT_WIDTH-1:0];
      end else if (shifted < SAT_MIN) begin
        data_out[i] = SAT_MIN[OUT_WIDTH-1:0];
      end else begin
        data_out[i] = shifted[OUT_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/skid_buffer.sv
`default_nettype none

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] main_q;
  logic [DATA_WIDTH-1:0] skid_q;
  logic main_valid;
  logic skid_valid;
  logic accept;
  logic load_main;

  // ready comes straight off the skid flag, so it is a flop output
  assign in_ready = ~skid_valid;
  assign accept = in_valid & ~skid_valid;

  // the main register is free when empty or when its word leaves this cycle
  assign load_main = ~main_valid | out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_main) begin
      // a parked word always goes first, which keeps the order
      main_valid <= skid_valid | accept;
      skid_valid <= 1'b0;
    end else if (accept) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      if (skid_valid) begin
        main_q <= skid_q;
      end else if (accept) begin
        main_q <= data_in;
      end
    end else if (accept) begin
      // the output is stalled, park the incoming word
      skid_q <= data_in;
    end
  end

  assign data_out = main_q;
  assign out_valid = main_valid;

endmodule

`default_nettype wire

//--- rtl/fixed_linear.sv
`default_nettype none

module fixed_linear
  import linear_pkg::*;
#(
  parameter int IN_WIDTH   = DEF_IN_WIDTH,
  parameter int IN_FRAC    = DEF_IN_FRAC,
  parameter int W_WIDTH    = DEF_W_WIDTH,
  parameter int W_FRAC     = DEF_W_FRAC,
  parameter int BIAS_WIDTH = DEF_BIAS_WIDTH,
  parameter int BIAS_FRAC  = DEF_BIAS_FRAC,
  parameter int OUT_WIDTH  = DEF_OUT_WIDTH,
  parameter int OUT_FRAC   = DEF_OUT_FRAC,
  parameter int IN_PAR     = DEF_IN_PAR,
  parameter int OUT_PAR    = DEF_OUT_PAR,
  parameter int IN_DEPTH   = DEF_IN_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic [IN_WIDTH-1:0]   data_in [IN_PAR-1:0],
  input  logic                  data_in_valid,
  output logic                  data_in_ready,

  input  logic [W_WIDTH-1:0]    weight [OUT_PAR*IN_PAR-1:0],
  input  logic                  weight_valid,
  output logic                  weight_ready,

  input  logic [BIAS_WIDTH-1:0] bias [OUT_PAR-1:0],
  input  logic                  bias_valid,
  output logic                  bias_ready,

  output logic [OUT_WIDTH-1:0]  data_out [OUT_PAR-1:0],
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  localparam int FDP_WIDTH = fdp_width(IN_WIDTH, W_WIDTH, IN_PAR);
  localparam int ACC_WIDTH = acc_width(IN_WIDTH, W_WIDTH, IN_PAR, IN_DEPTH);
  localparam int ACC_FRAC = IN_FRAC + W_FRAC;

  logic in_join_valid;
  logic [OUT_PAR-1:0] fdp_in_ready;
  logic fdp_ready;

  logic [OUT_PAR-1:0] acc_valid;
  logic acc_all_valid;
  logic acc_ready;

  logic bias_join_valid;
  logic [OUT_PAR-1:0] skid_in_ready;
  logic skid_ready;
  logic [OUT_PAR-1:0] skid_out_valid;

  logic [ACC_WIDTH-1:0] acc_data [OUT_PAR-1:0];
  logic [ACC_WIDTH-1:0] bias_acc [OUT_PAR-1:0];
  logic [ACC_WIDTH-1:0] sum_data [OUT_PAR-1:0];
  logic [ACC_WIDTH-1:0] buf_data [OUT_PAR-1:0];

  // all lanes see the same handshakes and move in lockstep, so reducing
  // their flags gives the same value as reading lane 0 alone
  assign fdp_ready = &fdp_in_ready;
  assign acc_all_valid = &acc_valid;
  assign skid_ready = &skid_in_ready;
  assign data_out_valid = &skid_out_valid;

  // activations and weights are taken together or not at all
  assign in_join_valid = data_in_valid & weight_valid;
  assign data_in_ready = fdp_ready & weight_valid;
  assign weight_ready = fdp_ready & data_in_valid;

  // accumulated sums meet the bias before entering the skid buffers
  assign bias_join_valid = acc_all_valid & bias_valid;
  assign acc_ready = skid_ready & bias_valid;
  assign bias_ready = skid_ready & acc_all_valid;

  // bias moved onto the accumulator binary point and widened
  fixed_rounding #(
    .IN_SIZE  (OUT_PAR),
    .IN_WIDTH (BIAS_WIDTH),
    .IN_FRAC  (BIAS_FRAC),
    .OUT_WIDTH(ACC_WIDTH),
    .OUT_FRAC (ACC_FRAC)
  ) i_bias_cast (
    .data_in (bias),
    .data_out(bias_acc)
  );

  for (genvar j = 0; j < OUT_PAR; j++) begin : g_lane
    logic [W_WIDTH-1:0] lane_weight [IN_PAR-1:0];
    logic [FDP_WIDTH-1:0] fdp_data;
    logic fdp_valid;
    logic fdp_out_ready;

    // lane j owns one contiguous row of the weight tile
    for (genvar k = 0; k < IN_PAR; k++) begin : g_slice
      assign lane_weight[k] = weight[j*IN_PAR+k];
    end

    fixed_dot_product #(
      .IN_WIDTH(IN_WIDTH),
      .W_WIDTH (W_WIDTH),
      .IN_PAR  (IN_PAR)
    ) i_fixed_dot_product (
      .clk      (clk),
      .rst_n    (rst_n),
      .data_in  (data_in),
      .weight   (lane_weight),
      .in_valid (in_join_valid),
      .in_ready (fdp_in_ready[j]),
      .data_out (fdp_data),
      .out_valid(fdp_valid),
      .out_ready(fdp_out_ready)
    );

    fixed_accumulator #(
      .IN_WIDTH(FDP_WIDTH),
      .IN_DEPTH(IN_DEPTH)
    ) i_fixed_accumulator (
      .clk      (clk),
      .rst_n    (rst_n),
      .data_in  (fdp_data),
      .in_valid (fdp_valid),
      .in_ready (fdp_out_ready),
      .data_out (acc_data[j]),
      .out_valid(acc_valid[j]),
      .out_ready(acc_ready)
    );

    assign sum_data[j] = $signed(acc_data[j]) + $signed(bias_acc[j]);

    skid_buffer #(
      .DATA_WIDTH(ACC_WIDTH)
    ) i_skid_buffer (
      .clk      (clk),
      .rst_n    (rst_n),
      .data_in  (sum_data[j]),
      .in_valid (bias_join_valid),
      .in_ready (skid_in_ready[j]),
      .data_out (buf_data[j]),
      .out_valid(skid_out_valid[j]),
      .out_ready(data_out_ready)
    );
  end

  // buffered sums brought down to the output format
  fixed_rounding #(
    .IN_SIZE  (OUT_PAR),
    .IN_WIDTH (ACC_WIDTH),
    .IN_FRAC  (ACC_FRAC),
    .OUT_WIDTH(OUT_WIDTH),
    .OUT_FRAC (OUT_FRAC)
  ) i_out_round (
    .data_in (buf_data),
    .data_out(data_out)
  );

endmodule

`default_nettype wire

//--- verif/tb_fixed_linear.sv
`default_nettype none

module tb_fixed_linear
  import linear_pkg::*;
;

  localparam int IN_PAR = DEF_IN_PAR;
  localparam int OUT_PAR = DEF_OUT_PAR;
  localparam int IN_DEPTH = DEF_IN_DEPTH;
  localparam int ACC_FRAC = DEF_IN_FRAC + DEF_W_FRAC;
  localparam int OUT_MAX = (1 << (DEF_OUT_WIDTH - 1)) - 1;
  localparam int OUT_MIN = -(1 << (DEF_OUT_WIDTH - 1));
  localparam int MAX_TILES = 8;
  // about 19 tiles of 4 beats plus the idle and stall windows, with a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic clk = 1'b0;
  logic rst_n;
  logic [DEF_IN_WIDTH-1:0] data_in [IN_PAR-1:0];
  logic data_in_valid;
  logic data_in_ready;
  logic [DEF_W_WIDTH-1:0] weight [OUT_PAR*IN_PAR-1:0];
  logic weight_valid;
  logic weight_ready;
  logic [DEF_BIAS_WIDTH-1:0] bias [OUT_PAR-1:0];
  logic bias_valid;
  logic bias_ready;
  logic [DEF_OUT_WIDTH-1:0] data_out [OUT_PAR-1:0];
  logic data_out_valid;
  logic data_out_ready;

  // stimulus for up to MAX_TILES tiles, indexed by tile and beat
  logic [DEF_IN_WIDTH-1:0] tile_act [MAX_TILES][IN_DEPTH][IN_PAR];
  logic [DEF_W_WIDTH-1:0] tile_wgt [MAX_TILES][IN_DEPTH][OUT_PAR*IN_PAR];
  logic [DEF_BIAS_WIDTH-1:0] tile_bias [MAX_TILES][OUT_PAR];

  int exp_q [$];
  string test_name;
  integer seed = 32'h52349216;
  int cycle_count = 0;

  fixed_linear i_fixed_linear (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in       (data_in),
    .data_in_valid (data_in_valid),
    .data_in_ready (data_in_ready),
    .weight        (weight),
    .weight_valid  (weight_valid),
    .weight_ready  (weight_ready),
    .bias          (bias),
    .bias_valid    (bias_valid),
    .bias_ready    (bias_ready),
    .data_out      (data_out),
    .data_out_valid(data_out_valid),
    .data_out_ready(data_out_ready)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout in %s: the run did not finish within %0d cycles", test_name,
               TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // full-precision dot products, bias aligned to the accumulator point, then floor and clamp
  function automatic int model_lane(input int t, input int j);
    int acc;
    int res;
    acc = 0;
    for (int d = 0; d < IN_DEPTH; d++) begin
      for (int k = 0; k < IN_PAR; k++) begin
        acc += int'($signed(tile_act[t][d][k])) * int'($signed(tile_wgt[t][d][j*IN_PAR+k]));
      end
    end
    acc += int'($signed(tile_bias[t][j])) <<< (ACC_FRAC - DEF_BIAS_FRAC);
    res = acc >>> (ACC_FRAC - DEF_OUT_FRAC);
    if (res > OUT_MAX) begin
      res = OUT_MAX;
    end else if (res < OUT_MIN) begin
      res = OUT_MIN;
    end
    return res;
  endfunction

  task automatic random_tiles(input int n);
    logic [31:0] rnd;
    for (int t = 0; t < n; t++) begin
      for (int d = 0; d < IN_DEPTH; d++) begin
        for (int k = 0; k < IN_PAR; k++) begin
          rnd = $random(seed);
          tile_act[t][d][k] = rnd[DEF_IN_WIDTH-1:0];
        end
        for (int m = 0; m < OUT_PAR*IN_PAR; m++) begin
          rnd = $random(seed);
          tile_wgt[t][d][m] = rnd[DEF_W_WIDTH-1:0];
        end
      end
      for (int j = 0; j < OUT_PAR; j++) begin
        rnd = $random(seed);
        tile_bias[t][j] = rnd[DEF_BIAS_WIDTH-1:0];
      end
    end
  endtask

  task automatic queue_expected(input int n);
    for (int t = 0; t < n; t++) begin
      for (int j = 0; j < OUT_PAR; j++) begin
        exp_q.push_back(model_lane(t, j));
      end
    end
  endtask

  task automatic drive_inputs(input int n);
    bit taken;
    for (int t = 0; t < n; t++) begin
      for (int d = 0; d < IN_DEPTH; d++) begin
        for (int k = 0; k < IN_PAR; k++) begin
          data_in[k] = tile_act[t][d][k];
        end
        for (int m = 0; m < OUT_PAR*IN_PAR; m++) begin
          weight[m] = tile_wgt[t][d][m];
        end
        data_in_valid = 1'b1;
        weight_valid = 1'b1;
        do begin
          @(negedge clk);
          taken = data_in_ready && weight_ready;
          @(posedge clk);
          #2;
        end while (!taken);
      end
    end
    data_in_valid = 1'b0;
    weight_valid = 1'b0;
  endtask

  task automatic drive_biases(input int n);
    bit taken;
    for (int t = 0; t < n; t++) begin
      for (int j = 0; j < OUT_PAR; j++) begin
        bias[j] = tile_bias[t][j];
      end
      bias_valid = 1'b1;
      do begin
        @(negedge clk);
        taken = bias_ready;
        @(posedge clk);
        #2;
      end while (!taken);
    end
    bias_valid = 1'b0;
  endtask

  task automatic collect_outputs(input int n, input bit toggle_ready);
    logic [31:0] rnd;
    int got;
    int expected;
    int actual;
    got = 0;
    while (got < n) begin
      rnd = $random(seed);
      data_out_ready = toggle_ready ? rnd[0] : 1'b1;
      @(negedge clk);
      if (data_out_valid && data_out_ready) begin
        for (int j = 0; j < OUT_PAR; j++) begin
          expected = exp_q.pop_front();
          actual = int'($signed(data_out[j]));
          assert (actual == expected) else begin
            $display("Mismatch in %s, result %0d lane %0d: expected %0d, actual %0d",
                     test_name, got, j, expected, actual);
            stop_with_failure();
          end
        end
        got++;
      end
      @(posedge clk);
      #2;
    end
    data_out_ready = 1'b1;
  endtask

  task automatic expect_idle_output(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!data_out_valid) else begin
        $display("%s: data_out_valid went high when no result was due", test_name);
        stop_with_failure();
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic test_reset_idle();
    test_name = "test_reset_idle";
    // with nothing offered the joined readies stay low as well
    repeat (10) begin
      @(negedge clk);
      assert (!data_out_valid && !data_in_ready && !weight_ready && !bias_ready) else begin
        $display("%s: a valid or ready was high with no input offered", test_name);
        stop_with_failure();
      end
      @(posedge clk);
      #2;
    end
    weight_valid = 1'b1;
    @(negedge clk);
    assert (data_in_ready && !weight_ready) else begin
      $display("%s: data_in_ready did not follow weight_valid after reset", test_name);
      stop_with_failure();
    end
    @(posedge clk);
    #2;
    weight_valid = 1'b0;
    data_in_valid = 1'b1;
    @(negedge clk);
    assert (weight_ready && !data_in_ready) else begin
      $display("%s: weight_ready did not follow data_in_valid after reset", test_name);
      stop_with_failure();
    end
    @(posedge clk);
    #2;
    data_in_valid = 1'b0;
  endtask

  task automatic test_single_tile();
    test_name = "test_single_tile";
    random_tiles(1);
    queue_expected(1);
    fork
      drive_inputs(1);
      drive_biases(1);
      collect_outputs(1, 1'b0);
    join
    expect_idle_output(10);
  endtask

  task automatic test_stream(input string name, input bit toggle_ready);
    test_name = name;
    random_tiles(MAX_TILES);
    queue_expected(MAX_TILES);
    fork
      drive_inputs(MAX_TILES);
      drive_biases(MAX_TILES);
      collect_outputs(MAX_TILES, toggle_ready);
    join
    expect_idle_output(10);
  endtask

  task automatic test_bias_stall();
    test_name = "test_bias_stall";
    random_tiles(1);
    queue_expected(1);
    drive_inputs(1);
    expect_idle_output(20);
    fork
      drive_biases(1);
      collect_outputs(1, 1'b0);
    join
  endtask

  task automatic test_saturation();
    test_name = "test_saturation";
    // lane 0 gets the largest positive products, lane 1 the largest negative ones
    for (int d = 0; d < IN_DEPTH; d++) begin
      for (int k = 0; k < IN_PAR; k++) begin
        tile_act[0][d][k] = 8'h7f;
        tile_wgt[0][d][k] = 8'h7f;
        tile_wgt[0][d][IN_PAR+k] = 8'h80;
      end
    end
    tile_bias[0][0] = 8'h7f;
    tile_bias[0][1] = 8'h80;
    assert (model_lane(0, 0) == OUT_MAX && model_lane(0, 1) == OUT_MIN) else begin
      $display("%s: the operands do not drive the model into saturation", test_name);
      stop_with_failure();
    end
    queue_expected(1);
    fork
      drive_inputs(1);
      drive_biases(1);
      collect_outputs(1, 1'b0);
    join
  endtask

  initial begin
    test_name = "reset";
    rst_n = 1'b0;
    data_in_valid = 1'b0;
    weight_valid = 1'b0;
    bias_valid = 1'b0;
    data_out_ready = 1'b1;
    for (int k = 0; k < IN_PAR; k++) begin
      data_in[k] = '0;
    end
    for (int m = 0; m < OUT_PAR*IN_PAR; m++) begin
      weight[m] = '0;
    end
    for (int j = 0; j < OUT_PAR; j++) begin
      bias[j] = '0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_idle();
    test_single_tile();
    test_stream("test_stream", 1'b0);
    test_stream("test_backpressure", 1'b1);
    test_bias_stall();
    test_saturation();

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
rtl/linear_pkg.sv
rtl/fixed_dot_product.sv
rtl/fixed_accumulator.sv
rtl/fixed_rounding.sv
rtl/skid_buffer.sv
rtl/fixed_linear.sv
verif/tb_fixed_linear.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fixed_linear testbench with Verilator, then judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fixed_linear -f src.f \
  -o sim_fixed_linear || { echo "build failed"; exit 1; }
./obj_dir/sim_fixed_linear > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
